// File: src/pool_defs.svh
`ifndef POOL_DEFS_SVH
`define POOL_DEFS_SVH

// IEEE half precision element format
`define POOL_DATA_W      16
`define POOL_MAN_W       10
`define POOL_EXP_W       (`POOL_DATA_W - `POOL_MAN_W - 1)

// 3x3 window
`define POOL_WIN_N       9

// Elements that go through the sorting network
`define POOL_SORT_N      8

// log2(8) * (log2(8) + 1) / 2 compare-exchange stages
`define POOL_SORT_STAGES 6

`endif

// File: src/pool_pkg.sv
`include "pool_defs.svh"

package pool_pkg;

    // One fp16 value
    typedef struct packed {
        logic                   sign;
        logic [`POOL_EXP_W-1:0] exponent;
        logic [`POOL_MAN_W-1:0] mantissa;
    } fp16_t;

    // Pooling window with element 0 in the low bits
    typedef fp16_t [`POOL_WIN_N-1:0] window_t;

    // Values moving through the bitonic network
    typedef fp16_t [`POOL_SORT_N-1:0] sort_vec_t;

    // One window in flight through the network
    typedef struct packed {
        logic      valid;
        sort_vec_t vec;
        fp16_t     spare;  // Ninth element that skips the sort
    } sort_beat_t;

    // Magnitude bits without the sign
    typedef logic [`POOL_DATA_W-2:0] fp16_mag_t;

    function automatic fp16_mag_t fp16_mag(input fp16_t v);
        return {v.exponent, v.mantissa};
    endfunction

    function automatic logic fp16_is_zero(input fp16_t v);
        return fp16_mag(v) == '0;
    endfunction

    // Strict a > b in value order for non-NaN inputs
    function automatic logic fp16_gt(input fp16_t a, input fp16_t b);
        fp16_mag_t mag_a;
        fp16_mag_t mag_b;
        mag_a = fp16_mag(a);
        mag_b = fp16_mag(b);
        if (fp16_is_zero(a) && fp16_is_zero(b)) begin
            return 1'b0;  // +0 == -0
        end
        // With differing signs the positive one is larger
        if (a.sign != b.sign) begin
            return b.sign;
        end
        if (a.sign) begin
            return mag_a < mag_b;  // Both negative
        end
        return mag_a > mag_b;
    endfunction

endpackage

// File: src/bitonic_stage.sv
`timescale 1ns/1ps
`include "pool_defs.svh"

module bitonic_stage #(
    parameter int STAGE = 0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  pool_pkg::sort_beat_t i_beat,
    output pool_pkg::sort_beat_t o_beat
);
    import pool_pkg::*;

    localparam int LANES = `POOL_SORT_N / 2;

    // Distance between the two elements of a pair
    localparam int DIST = (STAGE == 3) ? 4 :
                          (STAGE == 1 || STAGE == 4) ? 2 : 1;

    // Width of a run that shares one direction
    // Stage 0 alternates every pair, stages 1-2 every half, then all ascending
    localparam int BLOCK = (STAGE == 0) ? 2 :
                           (STAGE <= 2) ? 4 : `POOL_SORT_N;

    if (STAGE < 0 || STAGE >= `POOL_SORT_STAGES) begin : g_bad_stage
        $error("bitonic_stage: STAGE %0d out of range", STAGE);
    end

    // Lower index of a lane's pair
    function automatic int lane_lo(input int lane);
        return (lane / DIST) * 2 * DIST + (lane % DIST);
    endfunction

    // Descending lanes put the larger value at the lower index
    function automatic logic lane_desc(input int lo);
        return (lo & BLOCK) != 0;
    endfunction

    // True when the pair is out of order for its direction
    function automatic logic pair_swap(
        input fp16_t lo_val,
        input fp16_t hi_val,
        input logic  desc
    );
        return desc ? fp16_gt(hi_val, lo_val) : fp16_gt(lo_val, hi_val);
    endfunction

    sort_vec_t next_vec;

    // Four compare-exchange lanes
    always_comb begin
        int lo;
        int hi;
        next_vec = i_beat.vec;
        for (int l = 0; l < LANES; l++) begin
            lo = lane_lo(l);
            hi = lo + DIST;
            if (pair_swap(i_beat.vec[lo], i_beat.vec[hi], lane_desc(lo))) begin
                next_vec[lo] = i_beat.vec[hi];
                next_vec[hi] = i_beat.vec[lo];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_beat <= '0;
        end else begin
            o_beat.valid <= i_beat.valid;
            o_beat.vec   <= next_vec;
            o_beat.spare <= i_beat.spare;  // Rides along unsorted
        end
    end

    // Registered pairs must already sit in their lane's order
    for (genvar l = 0; l < LANES; l++) begin : g_check
        localparam int LO = lane_lo(l);
        localparam int HI = LO + DIST;

        a_pair_order: assert property (
            @(posedge clk) disable iff (!rst_n)
            o_beat.valid |-> !pair_swap(o_beat.vec[LO], o_beat.vec[HI], lane_desc(LO))
        ) else $error("stage %0d pair (%0d,%0d) out of order: %h %h",
                      STAGE, LO, HI, o_beat.vec[LO], o_beat.vec[HI]);
    end

endmodule

// File: src/pool_max_select.sv
`timescale 1ns/1ps
`include "pool_defs.svh"

module pool_max_select (
    input  logic                 clk,
    input  logic                 rst_n,
    input  pool_pkg::sort_beat_t i_beat,
    output logic                 o_valid,
    output pool_pkg::fp16_t      o_max
);
    import pool_pkg::*;

    fp16_t top;
    fp16_t pick;

    // Largest of the sorted eight
    assign top = i_beat.vec[`POOL_SORT_N-1];

    // On a tie the spare element wins
    assign pick = fp16_gt(top, i_beat.spare) ? top : i_beat.spare;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_valid <= 1'b0;
            o_max   <= '0;
        end else begin
            o_valid <= i_beat.valid;
            if (i_beat.valid) begin
                o_max <= pick;  // Held between windows
            end
        end
    end

    a_valid_source: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(o_valid) |-> $past(i_beat.valid)
    ) else $error("o_valid rose without a valid input beat");

endmodule

// File: src/max_pool_3x3.sv
`timescale 1ns/1ps
`include "pool_defs.svh"

module max_pool_3x3 (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              i_valid,
    input  pool_pkg::window_t i_window,
    output logic              o_valid,
    output pool_pkg::fp16_t   o_max
);
    import pool_pkg::*;

    if (`POOL_WIN_N != `POOL_SORT_N + 1) begin : g_bad_window
        $error("max_pool_3x3: window must be sort width plus one spare");
    end

    // beat[s] feeds stage s and the last one feeds the selector
    sort_beat_t beat [0:`POOL_SORT_STAGES];

    // Element 8 bypasses the network
    assign beat[0] = '{
        valid: i_valid,
        vec:   i_window[`POOL_SORT_N-1:0],
        spare: i_window[`POOL_WIN_N-1]
    };

    for (genvar s = 0; s < `POOL_SORT_STAGES; s++) begin : g_stage
        bitonic_stage #(
            .STAGE (s)
        ) u_stage (
            .clk    (clk),
            .rst_n  (rst_n),
            .i_beat (beat[s]),
            .o_beat (beat[s+1])
        );
    end

    pool_max_select u_select (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_beat  (beat[`POOL_SORT_STAGES]),
        .o_valid (o_valid),
        .o_max   (o_max)
    );

endmodule

// File: sim/tb_pool_tasks.svh
// Value rank for ordering where both zeros map to 0
function automatic int order_key(input fp16_t v);
    int mag;
    mag = int'({v.exponent, v.mantissa});
    if (mag == 0) begin
        return 0;
    end
    return v.sign ? -mag : mag;
endfunction

// Spare wins unless the largest of the first eight strictly beats it
function automatic fp16_t expected_max(input window_t w);
    fp16_t best;
    best = w[0];
    for (int i = 1; i < `POOL_SORT_N; i++) begin
        if (order_key(w[i]) > order_key(best)) begin
            best = w[i];
        end
    end
    if (order_key(best) > order_key(w[`POOL_WIN_N-1])) begin
        return best;
    end
    return w[`POOL_WIN_N-1];
endfunction

// Any finite nonzero value
function automatic fp16_t random_fp16();
    fp16_t v;
    v.sign     = 1'($urandom);
    v.exponent = 5'($urandom_range(0, 30));
    v.mantissa = 10'($urandom);
    if (v.exponent == '0 && v.mantissa == '0) begin
        v.mantissa = 10'd1;  // Keep signed zeros out of random windows
    end
    return v;
endfunction

// Positive and below 128.0
function automatic fp16_t small_positive();
    fp16_t v;
    v.sign     = 1'b0;
    v.exponent = 5'($urandom_range(1, 21));
    v.mantissa = 10'($urandom);
    return v;
endfunction

task automatic check_max(input fp16_t got, input fp16_t want);
    if (got !== want) begin
        $display("[ERROR] o_max: got %h, expected %h", got, want);
        report_failure("result mismatch");
    end
endtask

task automatic check_latency(input int got, input int want);
    if (got != want) begin
        $display("[ERROR] o_valid latency: got %h cycles, expected %h", got, want);
        report_failure("latency mismatch");
    end
endtask

task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
        $display("[ERROR] %s: got %h, expected %h", name, got, want);
        report_failure("control signal mismatch");
    end
endtask

task automatic check_count(input string name, input int got, input int want);
    if (got != want) begin
        $display("[ERROR] %s: got %h, expected %h", name, got, want);
        report_failure("count mismatch");
    end
endtask

task automatic drive_idle(input int n);
    for (int i = 0; i < n; i++) begin
        @(negedge clk);
        i_valid  = 1'b0;
        i_window = '0;
    end
endtask

// Sampled at the next rising edge, so that edge is the input cycle
task automatic send_window(input window_t w, input fp16_t want);
    @(negedge clk);
    i_valid  = 1'b1;
    i_window = w;
    exp_q.push_back(want);
    born_q.push_back(cycle + 1);
    sent_count++;
endtask

task automatic wait_results(input int limit);
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
        if (waited >= limit) begin
            report_failure("timed out waiting for o_valid");
        end else begin
            drive_idle(1);
            waited++;
        end
    end
    check_count("o_valid pulses", recv_count, sent_count);
endtask

task automatic test_reset_idle();
    for (int i = 0; i < 20; i++) begin
        drive_idle(1);
        check_flag("o_valid", o_valid, 1'b0);
    end
endtask

task automatic test_single_window();
    window_t w;
    fp16_t   peak;
    peak = 16'h5a00;  // 192.0
    for (int pos = 0; pos < `POOL_WIN_N; pos++) begin
        for (int i = 0; i < `POOL_WIN_N; i++) begin
            w[i] = small_positive();
        end
        w[pos] = peak;
        send_window(w, peak);
        wait_results(50);
    end
endtask

// Windows listed from element 8 down to element 0
task automatic test_sign_ordering();
    // All negative with -0.25 largest
    send_window({16'hba00, 16'hc800, 16'hbe00, 16'hc400, 16'hb400,
                 16'hc200, 16'hb800, 16'hc000, 16'hbc00}, 16'hb400);
    // All negative with -inf and spare -0.5 largest
    send_window({16'hb800, 16'hd000, 16'hcc00, 16'hc800, 16'hc200,
                 16'hc400, 16'hbc00, 16'hfc00, 16'hc000}, 16'hb800);
    // Mixed signs with 2.0 largest
    send_window({16'hc200, 16'h0001, 16'hc000, 16'h3e00, 16'h8000,
                 16'h4000, 16'hd640, 16'h3800, 16'hbc00}, 16'h4000);
    // Spare just above 1.0
    send_window({16'h3c01, 16'h3800, 16'h8001, 16'h3bff, 16'h0000,
                 16'hc000, 16'h3555, 16'hbc00, 16'h3c00}, 16'h3c01);
    // Spare ties the largest of the eight
    send_window({16'h4200, 16'h41ff, 16'h3e00, 16'h0000, 16'hc200,
                 16'h4000, 16'h4200, 16'hb800, 16'h3c00}, 16'h4200);
    // Spare -0 wins the tie against +0 among the eight
    send_window({16'h8000, 16'h8001, 16'hfc00, 16'h0000, 16'hc200,
                 16'h8400, 16'hb800, 16'hc000, 16'hbc00}, 16'h8000);
    // -0 among the eight against spare +0
    send_window({16'h0000, 16'h8123, 16'hc400, 16'hb800, 16'hfc00,
                 16'h8001, 16'hbc00, 16'h8000, 16'hc000}, 16'h0000);
    // Smallest subnormal beats spare -0
    send_window({16'h8000, 16'h83ff, 16'hb000, 16'hfc00, 16'h8200,
                 16'h0001, 16'hc000, 16'hbc00, 16'h8001}, 16'h0001);
    wait_results(50);
endtask

task automatic test_back_to_back();
    window_t w;
    for (int n = 0; n < 20; n++) begin
        for (int i = 0; i < `POOL_WIN_N; i++) begin
            w[i] = random_fp16();
        end
        send_window(w, expected_max(w));
    end
    wait_results(50);
endtask

task automatic test_random_gapped();
    window_t w;
    int      gap;
    for (int n = 0; n < 200; n++) begin
        for (int i = 0; i < `POOL_WIN_N; i++) begin
            w[i] = random_fp16();
        end
        send_window(w, expected_max(w));
        gap = $urandom_range(0, 4);
        if (gap > 0) begin
            drive_idle(gap);
        end
    end
    wait_results(100);
    drive_idle(20);  // Any stray pulse here hits the monitor
    check_count("o_valid pulses", recv_count, sent_count);
endtask

// File: sim/tb_max_pool_3x3.sv
`timescale 1ns/1ps
`include "pool_defs.svh"

module tb_max_pool_3x3;
    import pool_pkg::*;

    localparam int CLK_HALF     = 50;  // 100 ns period
    localparam int RESET_CYCLES = 10;

    // One register per sort stage and one in the selector
    localparam int PIPE_LATENCY = `POOL_SORT_STAGES + 1;

    logic    clk;
    logic    rst_n;
    logic    i_valid;
    window_t i_window;
    logic    o_valid;
    fp16_t   o_max;

    // Scoreboard of expected maxima and input cycles
    fp16_t exp_q[$];
    int    born_q[$];

    int cycle;       // Rising edges seen so far
    int sent_count;
    int recv_count;

    max_pool_3x3 u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_valid  (i_valid),
        .i_window (i_window),
        .o_valid  (o_valid),
        .o_max    (o_max)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    initial begin
        cycle = 0;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    `include "tb_pool_tasks.svh"

    // Monitor samples on the falling edge where outputs are settled
    always @(negedge clk) begin
        fp16_t want;
        int    born;
        if (rst_n && o_valid) begin
            if (exp_q.size() == 0) begin
                report_failure("o_valid pulsed with no window outstanding");
            end else begin
                want = exp_q.pop_front();
                born = born_q.pop_front();
                check_max(o_max, want);
                // A consumer samples this result at the next rising edge
                check_latency(cycle + 1 - born, PIPE_LATENCY);
                recv_count++;
            end
        end
    end

    initial begin
        void'($urandom(32'h24d8));
        sent_count = 0;
        recv_count = 0;
        rst_n      = 1'b0;
        i_valid    = 1'b0;
        i_window   = '0;

        // Outputs must stay quiet while reset is held
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_flag("o_valid", o_valid, 1'b0);
        end
        rst_n = 1'b1;

        test_reset_idle();
        test_single_window();
        test_sign_ordering();
        test_back_to_back();
        test_random_gapped();

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+src
+incdir+sim
src/pool_pkg.sv
src/bitonic_stage.sv
src/pool_max_select.sv
src/max_pool_3x3.sv
sim/tb_max_pool_3x3.sv
